//--- include/noc_flit_utils.svh
`ifndef NOC_FLIT_UTILS_SVH
`define NOC_FLIT_UTILS_SVH

// a one-flit packet counts as both header and tail.
function automatic logic is_header_flit(input noc_router_pkg::noc_flit flit);
  logic result;
  result = (flit.kind == noc_router_pkg::header) ||
           (flit.kind == noc_router_pkg::header_tail);
  return result;
endfunction

function automatic logic is_tail_flit(input noc_router_pkg::noc_flit flit);
  logic result;
  result = (flit.kind == noc_router_pkg::tail) ||
           (flit.kind == noc_router_pkg::header_tail);
  return result;
endfunction

// true when both coordinates fall inside the mesh.
function automatic logic dest_in_mesh(input noc_router_pkg::noc_location_id dest);
  logic x_ok;
  logic y_ok;
  x_ok = int'(dest.x) < noc_router_pkg::size_x;
  y_ok = int'(dest.y) < noc_router_pkg::size_y;
  return x_ok && y_ok;
endfunction

`endif

//--- src/noc_router_pkg.sv
`default_nettype none

package noc_router_pkg;

  // ============================================================
  // mesh and link sizes
  // ============================================================
  localparam int size_x      = 4;
  localparam int size_y      = 4;
  localparam int coord_width = 2;
  localparam int vc_count    = 2;
  localparam int vc_width    = $clog2(vc_count);
  localparam int port_count  = 5;
  localparam int data_width  = 32;

  // output port indices, also the XY priority order.
  localparam int port_x_plus  = 0;
  localparam int port_x_minus = 1;
  localparam int port_y_plus  = 2;
  localparam int port_y_minus = 3;
  localparam int port_local   = 4;

  typedef logic [vc_width-1:0]   vc_index;
  typedef logic [port_count-1:0] route_onehot;

  localparam route_onehot route_x_plus  = 5'b00001;
  localparam route_onehot route_x_minus = 5'b00010;
  localparam route_onehot route_y_plus  = 5'b00100;
  localparam route_onehot route_y_minus = 5'b01000;
  localparam route_onehot route_local   = 5'b10000;

  // ============================================================
  // flit format
  // ============================================================
  typedef struct packed {
    logic [coord_width-1:0] x;
    logic [coord_width-1:0] y;
  } noc_location_id;

  // bit 0 marks a header, bit 1 a tail.
  typedef enum logic [1:0] {
    body        = 2'b00,
    header      = 2'b01,
    tail        = 2'b10,
    header_tail = 2'b11
  } noc_flit_kind;

  typedef struct packed {
    noc_flit_kind            kind;
    vc_index                 vc;
    noc_location_id          dest;                 // header flits only.
    logic                    invalid_destination;
    logic [data_width-1:0]   data;
  } noc_flit;

endpackage

`default_nettype wire

//--- src/noc_vc_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module noc_vc_buffer #(
  parameter int depth = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_valid,
  input  noc_router_pkg::noc_flit wr_flit,
  output logic                    wr_ready,
  output logic                    rd_valid,
  output noc_router_pkg::noc_flit rd_flit,
  input  logic                    rd_ready
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_width = $clog2(depth + 1);

  noc_router_pkg::noc_flit mem [depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 push;
  logic                 pop;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    logic [ptr_width-1:0] result;
    result = (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
    return result;
  endfunction

  assign wr_ready = (count != cnt_width'(depth));
  assign rd_valid = (count != '0);
  assign rd_flit  = mem[rd_ptr];    // read straight from storage.
  assign push     = wr_valid && wr_ready;
  assign pop      = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;    // idle or pass-through.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_flit;
  end

endmodule

`default_nettype wire

//--- src/noc_route_selector.sv
`timescale 1ns/1ns
`default_nettype none

module noc_route_selector #(
  parameter int                          my_x            = 0,
  parameter int                          my_y            = 0,
  parameter noc_router_pkg::route_onehot available_ports = '1
) (
  input  noc_router_pkg::noc_flit [noc_router_pkg::vc_count-1:0]       flit_in,
  input  logic [noc_router_pkg::vc_count-1:0]                          flit_in_valid,
  output logic [noc_router_pkg::vc_count-1:0]                          flit_in_ready,
  input  noc_router_pkg::route_onehot [noc_router_pkg::vc_count-1:0]   port_grant,
  input  logic [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] accept,
  output logic [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] port_request,
  output logic [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] port_free,
  output logic [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] steer_valid,
  output noc_router_pkg::noc_flit [noc_router_pkg::vc_count-1:0]       steer_flit
);

  `include "noc_flit_utils.svh"

  // ============================================================
  // XY route decode
  // ============================================================
  function automatic noc_router_pkg::route_onehot select_route(
    input noc_router_pkg::noc_location_id dest
  );
    noc_router_pkg::route_onehot route;
    if (!dest_in_mesh(dest)) begin
      route = noc_router_pkg::route_local;
    end else if ((int'(dest.x) > my_x) && available_ports[noc_router_pkg::port_x_plus]) begin
      route = noc_router_pkg::route_x_plus;
    end else if ((int'(dest.x) < my_x) && available_ports[noc_router_pkg::port_x_minus]) begin
      route = noc_router_pkg::route_x_minus;
    end else if ((int'(dest.y) > my_y) && available_ports[noc_router_pkg::port_y_plus]) begin
      route = noc_router_pkg::route_y_plus;
    end else if ((int'(dest.y) < my_y) && available_ports[noc_router_pkg::port_y_minus]) begin
      route = noc_router_pkg::route_y_minus;
    end else begin
      route = noc_router_pkg::route_local;    // arrived, or no fitted port left.
    end
    return route;
  endfunction

  noc_router_pkg::route_onehot [noc_router_pkg::vc_count-1:0] route;
  logic [noc_router_pkg::vc_count-1:0]                        is_head;
  logic [noc_router_pkg::vc_count-1:0]                        is_last;

  always_comb begin
    for (int v = 0; v < noc_router_pkg::vc_count; v++) begin
      is_head[v]    = is_header_flit(flit_in[v]);
      is_last[v]    = is_tail_flit(flit_in[v]);
      route[v]      = select_route(flit_in[v].dest);
      steer_flit[v] = flit_in[v];
      if (is_head[v] && !dest_in_mesh(flit_in[v].dest)) begin
        steer_flit[v].invalid_destination = 1'b1;    // flag and send home.
      end
    end
  end

  // ============================================================
  // requests and steering by grant
  // ============================================================
  always_comb begin
    for (int p = 0; p < noc_router_pkg::port_count; p++) begin
      for (int v = 0; v < noc_router_pkg::vc_count; v++) begin
        port_request[p][v] = flit_in_valid[v] && is_head[v] && route[v][p];
        steer_valid[p][v]  = flit_in_valid[v] && port_grant[v][p];
      end
    end
  end

  always_comb begin
    flit_in_ready = '0;
    for (int v = 0; v < noc_router_pkg::vc_count; v++) begin
      for (int p = 0; p < noc_router_pkg::port_count; p++) begin
        if (port_grant[v][p] && accept[p][v]) flit_in_ready[v] = 1'b1;
      end
    end
  end

  // tail leaving releases the port it went to.
  always_comb begin
    for (int p = 0; p < noc_router_pkg::port_count; p++) begin
      for (int v = 0; v < noc_router_pkg::vc_count; v++) begin
        port_free[p][v] = flit_in_valid[v] && flit_in_ready[v] && is_last[v] &&
                          port_grant[v][p];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/noc_port_allocator.sv
`timescale 1ns/1ns
`default_nettype none

module noc_port_allocator (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [noc_router_pkg::vc_count-1:0] port_request,
  input  logic [noc_router_pkg::vc_count-1:0] port_free,
  input  logic [noc_router_pkg::vc_count-1:0] steer_valid,
  input  logic [noc_router_pkg::vc_count-1:0] transfer,
  output logic [noc_router_pkg::vc_count-1:0] port_grant,
  output logic [noc_router_pkg::vc_count-1:0] vc_select
);

  logic [noc_router_pkg::vc_count-1:0] owned;
  logic [noc_router_pkg::vc_count-1:0] candidates;
  noc_router_pkg::vc_index             rr_ptr;
  noc_router_pkg::vc_index             rr_ptr_next;

  // ============================================================
  // port ownership
  // ============================================================
  assign port_grant = port_request | owned;
  assign candidates = port_grant & steer_valid;

  // ============================================================
  // round-robin VC choice
  // ============================================================
  always_comb begin
    int   idx;
    logic found;
    found     = 1'b0;
    vc_select = '0;
    for (int i = 0; i < noc_router_pkg::vc_count; i++) begin
      idx = (int'(rr_ptr) + i) % noc_router_pkg::vc_count;
      if (!found && candidates[idx]) begin
        vc_select[idx] = 1'b1;
        found          = 1'b1;
      end
    end
  end

  // move just past whoever went last.
  always_comb begin
    rr_ptr_next = rr_ptr;
    for (int i = 0; i < noc_router_pkg::vc_count; i++) begin
      if (transfer[i]) begin
        rr_ptr_next = noc_router_pkg::vc_index'((i + 1) % noc_router_pkg::vc_count);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owned  <= '0;
      rr_ptr <= '0;
    end else begin
      // header_tail sets and frees at once, so it never holds.
      owned  <= (owned | (port_request & transfer)) & ~port_free;
      rr_ptr <= rr_ptr_next;
    end
  end

endmodule

`default_nettype wire

//--- src/noc_vc_merger.sv
`timescale 1ns/1ns
`default_nettype none

module noc_vc_merger (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [noc_router_pkg::vc_count-1:0]                    vc_select,
  input  noc_router_pkg::noc_flit [noc_router_pkg::vc_count-1:0] steer_flit,
  input  logic                                                   out_ready,
  output logic [noc_router_pkg::vc_count-1:0]                    accept,
  output logic                                                   out_valid,
  output noc_router_pkg::noc_flit                                out_flit
);

  logic                    load;
  logic                    any_select;
  noc_router_pkg::noc_flit picked;

  // register empty or draining this cycle.
  assign load       = !out_valid || out_ready;
  assign any_select = |vc_select;
  assign accept     = load ? vc_select : '0;

  // ============================================================
  // one-hot flit mux
  // ============================================================
  always_comb begin
    picked = '0;
    for (int v = 0; v < noc_router_pkg::vc_count; v++) begin
      if (vc_select[v]) picked = steer_flit[v];
    end
  end

  // ============================================================
  // output register
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= any_select;
    end
  end

  always_ff @(posedge clk) begin
    if (load && any_select) begin
      out_flit <= picked;    // vc field rides along unchanged.
    end
  end

endmodule

`default_nettype wire

//--- src/noc_input_router.sv
`timescale 1ns/1ns
`default_nettype none

module noc_input_router #(
  parameter int                          my_x            = 0,
  parameter int                          my_y            = 0,
  parameter noc_router_pkg::route_onehot available_ports = '1
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic [noc_router_pkg::vc_count-1:0]                      in_valid,
  output wire [noc_router_pkg::vc_count-1:0]                       in_ready,
  input  noc_router_pkg::noc_flit [noc_router_pkg::vc_count-1:0]   in_flit,
  output wire [noc_router_pkg::port_count-1:0]                     out_valid,
  input  logic [noc_router_pkg::port_count-1:0]                    out_ready,
  output wire noc_router_pkg::noc_flit [noc_router_pkg::port_count-1:0] out_flit
);

  wire [noc_router_pkg::vc_count-1:0]                          buf_valid;
  wire noc_router_pkg::noc_flit [noc_router_pkg::vc_count-1:0] buf_flit;
  wire [noc_router_pkg::vc_count-1:0]                          buf_ready;

  wire [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] port_request;
  wire [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] port_free;
  wire [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] steer_valid;
  wire [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] grant_by_port;
  wire [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] vc_select;
  wire [noc_router_pkg::port_count-1:0][noc_router_pkg::vc_count-1:0] accept;
  wire noc_router_pkg::route_onehot [noc_router_pkg::vc_count-1:0]    grant_by_vc;
  wire noc_router_pkg::noc_flit [noc_router_pkg::vc_count-1:0]        steer_flit;

  // ============================================================
  // input buffers, one per VC
  // ============================================================
  for (genvar v = 0; v < noc_router_pkg::vc_count; v++) begin : g_vc
    noc_vc_buffer u_buffer (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_valid (in_valid[v]),
      .wr_flit  (in_flit[v]),
      .wr_ready (in_ready[v]),
      .rd_valid (buf_valid[v]),
      .rd_flit  (buf_flit[v]),
      .rd_ready (buf_ready[v])
    );

    for (genvar p = 0; p < noc_router_pkg::port_count; p++) begin : g_grant
      assign grant_by_vc[v][p] = grant_by_port[p][v];    // per port to per VC.
    end
  end

  noc_route_selector #(
    .my_x            (my_x),
    .my_y            (my_y),
    .available_ports (available_ports)
  ) u_selector (
    .flit_in       (buf_flit),
    .flit_in_valid (buf_valid),
    .flit_in_ready (buf_ready),
    .port_grant    (grant_by_vc),
    .accept        (accept),
    .port_request  (port_request),
    .port_free     (port_free),
    .steer_valid   (steer_valid),
    .steer_flit    (steer_flit)
  );

  // ============================================================
  // allocator and merger per output port
  // ============================================================
  for (genvar p = 0; p < noc_router_pkg::port_count; p++) begin : g_port
    noc_port_allocator u_allocator (
      .clk          (clk),
      .rst_n        (rst_n),
      .port_request (port_request[p]),
      .port_free    (port_free[p]),
      .steer_valid  (steer_valid[p]),
      .transfer     (accept[p]),
      .port_grant   (grant_by_port[p]),
      .vc_select    (vc_select[p])
    );

    noc_vc_merger u_merger (
      .clk        (clk),
      .rst_n      (rst_n),
      .vc_select  (vc_select[p]),
      .steer_flit (steer_flit),
      .out_ready  (out_ready[p]),
      .accept     (accept[p]),
      .out_valid  (out_valid[p]),
      .out_flit   (out_flit[p])
    );
  end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;    // release on a rising edge.
  end

endmodule

`default_nettype wire

//--- bench/tb_noc_input_router.sv
`timescale 1ns/1ns
`default_nettype none

module tb_noc_input_router;

  localparam int node_x         = 1;
  localparam int node_y         = 1;
  localparam int packets_per_vc = 20;
  localparam int queue_count    = noc_router_pkg::port_count * noc_router_pkg::vc_count;

  logic                                                          clk;
  logic                                                          rst_n;
  logic [noc_router_pkg::vc_count-1:0]                           in_valid;
  logic [noc_router_pkg::vc_count-1:0]                           in_ready;
  noc_router_pkg::noc_flit [noc_router_pkg::vc_count-1:0]        in_flit;
  logic [noc_router_pkg::port_count-1:0]                         out_valid;
  logic [noc_router_pkg::port_count-1:0]                         out_ready;
  noc_router_pkg::noc_flit [noc_router_pkg::port_count-1:0]      out_flit;

  noc_router_pkg::noc_flit stim_q [noc_router_pkg::vc_count][$];
  noc_router_pkg::noc_flit expected_q [queue_count][$];    // index port * vc_count + vc.

  int value_errors  = 0;
  int flow_errors   = 0;
  int checked       = 0;
  int total_flits   = 0;
  int timeout_limit = 0;
  int cycle_count   = 0;

  tb_clock_gen clock0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  noc_input_router #(
    .my_x            (node_x),
    .my_y            (node_y),
    .available_ports (5'b11111)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit)
  );

  // ============================================================
  // reference model
  // ============================================================
  function automatic int expected_port(input int x, input int y);
    int port;
    if (x >= noc_router_pkg::size_x || y >= noc_router_pkg::size_y) port = 4;
    else if (x > node_x) port = 0;
    else if (x < node_x) port = 1;
    else if (y > node_y) port = 2;
    else if (y < node_y) port = 3;
    else port = 4;    // already home.
    return port;
  endfunction

  task automatic build_packets();
    noc_router_pkg::noc_flit         f;
    logic [noc_router_pkg::coord_width-1:0] dx;
    logic [noc_router_pkg::coord_width-1:0] dy;
    int                              len;
    int                              port;
    for (int v = 0; v < noc_router_pkg::vc_count; v++) begin
      for (int n = 0; n < packets_per_vc; n++) begin
        len = int'($urandom % 4) + 1;
        dx  = noc_router_pkg::coord_width'($urandom);
        dy  = noc_router_pkg::coord_width'($urandom);
        if (n == 0) begin
          dx  = 2'd3;    // both VCs open on X+ together.
          dy  = 2'd1;
          len = 4;
        end
        port = expected_port(int'(dx), int'(dy));
        for (int i = 0; i < len; i++) begin
          if (len == 1) f.kind = noc_router_pkg::header_tail;
          else if (i == 0) f.kind = noc_router_pkg::header;
          else if (i == len - 1) f.kind = noc_router_pkg::tail;
          else f.kind = noc_router_pkg::body;
          f.vc                  = noc_router_pkg::vc_index'(v);
          f.dest.x              = dx;
          f.dest.y              = dy;
          f.invalid_destination = 1'b0;
          f.data                = $urandom;
          stim_q[v].push_back(f);
          // every 2-bit coordinate lies inside a 4x4 mesh.
          if (i == 0 && (int'(dx) >= noc_router_pkg::size_x ||
                         int'(dy) >= noc_router_pkg::size_y)) begin
            f.invalid_destination = 1'b1;
          end
          expected_q[port * noc_router_pkg::vc_count + v].push_back(f);
          total_flits++;
        end
      end
    end
  endtask

  function automatic int outstanding();
    int sum;
    sum = 0;
    for (int q = 0; q < queue_count; q++) sum += expected_q[q].size();
    return sum;
  endfunction

  // ============================================================
  // stimulus
  // ============================================================
  task automatic drive_vc(input int v);
    noc_router_pkg::noc_flit f;
    logic                    taken;
    @(posedge clk);
    while (stim_q[v].size() > 0) begin
      f = stim_q[v].pop_front();
      in_valid[v] <= 1'b1;
      in_flit[v]  <= f;
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = in_ready[v];    // stable until the next edge.
        @(posedge clk);
      end
    end
    in_valid[v] <= 1'b0;
  endtask

  always @(posedge clk) begin
    logic [31:0] ready_bits;
    if (rst_n) begin
      ready_bits = $urandom | $urandom;    // about three in four ready.
      out_ready <= ready_bits[noc_router_pkg::port_count-1:0];
    end
  end

  // ============================================================
  // scoreboard
  // ============================================================
  task automatic check_output(input int p, input noc_router_pkg::noc_flit got);
    noc_router_pkg::noc_flit exp;
    int                      idx;
    idx = p * noc_router_pkg::vc_count + int'(got.vc);
    assert (expected_q[idx].size() > 0) else begin
      $display("flit on port %0d for vc %0d at %0t was never sent there",
               p, got.vc, $time);
      flow_errors++;
    end
    if (expected_q[idx].size() > 0) begin
      exp = expected_q[idx].pop_front();
      assert (got == exp) else begin
        $display("** Error at %0t: out_flit[%0d] = %h, expected %h", $time, p, got, exp);
        value_errors++;
      end
      checked++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < noc_router_pkg::port_count; p++) begin
        if (out_valid[p] && out_ready[p]) check_output(p, out_flit[p]);
      end
    end
  end

  task automatic report_counts();
    $display("checked %0d of %0d flits: %0d value errors, %0d flow errors",
             checked, total_flits, value_errors, flow_errors);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("timeout after %0d cycles with %0d flits still outstanding",
               cycle_count, outstanding());
      report_counts();
      $display("Something failed");
      $finish;
    end
  end

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    in_valid  = '0;
    in_flit   = '0;
    out_ready = '0;
    void'($urandom(32'h9056_7f41));
    build_packets();
    timeout_limit = 40 * total_flits + 100;

    @(posedge rst_n);
    @(negedge clk);
    assert (out_valid == '0) else begin
      $display("** Error at %0t: out_valid = %b, expected %b", $time, out_valid, 5'b0);
      value_errors++;
    end
    assert (in_ready == '1) else begin
      $display("** Error at %0t: in_ready = %b, expected %b", $time, in_ready, 2'b11);
      value_errors++;
    end

    fork
      drive_vc(0);
      drive_vc(1);
    join

    while (outstanding() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (out_valid == '0) else begin
      $display("** Error at %0t: out_valid = %b, expected %b", $time, out_valid, 5'b0);
      value_errors++;
    end

    report_counts();
    if (value_errors == 0 && flow_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
src/noc_router_pkg.sv
src/noc_vc_buffer.sv
src/noc_route_selector.sv
src/noc_port_allocator.sv
src/noc_vc_merger.sv
src/noc_input_router.sv
bench/tb_clock_gen.sv
bench/tb_noc_input_router.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the input router testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_noc_input_router \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
